//--- Makefile
# Verilator build and run for the sideband repeater testbench

VERILATOR ?= verilator
TOP       ?= tb_sberepeater
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
EXTRA     ?=

.PHONY: sim clean

# A failing run ends in $fatal, which makes the binary exit non-zero
sim:
	$(VERILATOR) $(VFLAGS) $(EXTRA) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- compile.f
+incdir+include
verilog/sberep_pkg.sv
verilog/sberep_fifo.sv
verilog/sberep_ctrl.sv
verilog/sberep_mst.sv
verilog/sberep_tgt.sv
verilog/sberepeater.sv
verification/tb_sberepeater.sv

//--- include/sberep_defines.svh
`ifndef SBEREP_DEFINES_SVH
`define SBEREP_DEFINES_SVH

// Flit payload width in bits
`define SBREP_PLD_W 32

// Entries per channel queue
`define SBREP_DEPTH 4

// Header opcodes that mark a completion
`define SBREP_OP_CMPL  8'h20
`define SBREP_OP_CMPLD 8'h21

`endif

//--- verification/tb_sberepeater.sv
`timescale 1ns/100ps
`default_nettype none

`include "sberep_defines.svh"

module tb_sberepeater
  import sberep_pkg::*;
;

  // ----------------------------
  // Clock, reset and control
  // ----------------------------
  logic   agent_clk;
  logic   rst;
  integer seed;
  logic   gen_en;
  logic   hold_sink;
  logic   bad_en;
  string  chn [2];

  // Index 0 is the pc channel and index 1 the np channel
  // Agent master source and endpoint master sink
  logic [1:0]              m_irdy;
  logic [1:0]              m_eom;
  logic [1:0]              m_par;
  logic [`SBREP_PLD_W-1:0] m_pld [2];
  logic [1:0]              ep_trdy;
  // Endpoint target source and agent target sink
  logic [1:0]              t_put;
  logic [1:0]              t_eom;
  logic [1:0]              t_par;
  logic [`SBREP_PLD_W-1:0] t_pld [2];
  logic [1:0]              free_ip;

  // DUT outputs
  wire [1:0]              trdy_ip;
  wire [1:0]              msgip_ip;
  wire [1:0]              m_irdy_ep;
  wire [1:0]              m_eom_ep;
  wire [`SBREP_PLD_W-1:0] m_pld_ep [2];
  wire [1:0]              sel_ep;
  wire [1:0]              free_ep;
  wire [1:0]              t_put_ip;
  wire [1:0]              t_eom_ip;
  wire [`SBREP_PLD_W-1:0] t_pld_ip [2];
  wire                    cmpl;
  wire                    parity_err;
  wire                    fifo_empty;

  // Generator state owned by the drive block
  int   m_left [2];
  logic m_first [2];
  int   t_left [2];
  logic t_first [2];

  // Reference model owned by the monitor
  logic [`SBREP_PLD_W:0] mst_q [2][$];
  logic [`SBREP_PLD_W:0] tgt_q [2][$];
  logic [1:0] m_acc;
  logic [1:0] t_can_put;
  logic [1:0] exp_msgip;
  logic [1:0] t_open;
  logic       exp_perr;
  logic       prev_empty;
  logic       t_hdr;
  logic       lock_on;
  sb_chan_e   lock_ch;

  sberepeater sberepeater_inst (
    .agent_clk         (agent_clk),
    .rst               (rst),
    .mmsg_pcirdy_ip    (m_irdy[0]),
    .mmsg_npirdy_ip    (m_irdy[1]),
    .mmsg_pceom_ip     (m_eom[0]),
    .mmsg_npeom_ip     (m_eom[1]),
    .mmsg_pcparity_ip  (m_par[0]),
    .mmsg_npparity_ip  (m_par[1]),
    .mmsg_pcpayload_ip (m_pld[0]),
    .mmsg_nppayload_ip (m_pld[1]),
    .mmsg_pctrdy_ip    (trdy_ip[0]),
    .mmsg_nptrdy_ip    (trdy_ip[1]),
    .mmsg_pcmsgip_ip   (msgip_ip[0]),
    .mmsg_npmsgip_ip   (msgip_ip[1]),
    .tmsg_pcfree_ip    (free_ip[0]),
    .tmsg_npfree_ip    (free_ip[1]),
    .tmsg_pcput_ip     (t_put_ip[0]),
    .tmsg_npput_ip     (t_put_ip[1]),
    .tmsg_pceom_ip     (t_eom_ip[0]),
    .tmsg_npeom_ip     (t_eom_ip[1]),
    .tmsg_pcpayload_ip (t_pld_ip[0]),
    .tmsg_nppayload_ip (t_pld_ip[1]),
    .tmsg_pccmpl_ip    (cmpl),
    .mmsg_pcirdy_ep    (m_irdy_ep[0]),
    .mmsg_npirdy_ep    (m_irdy_ep[1]),
    .mmsg_pceom_ep     (m_eom_ep[0]),
    .mmsg_npeom_ep     (m_eom_ep[1]),
    .mmsg_pcpayload_ep (m_pld_ep[0]),
    .mmsg_nppayload_ep (m_pld_ep[1]),
    .mmsg_pcsel_ep     (sel_ep[0]),
    .mmsg_npsel_ep     (sel_ep[1]),
    .mmsg_pctrdy_ep    (ep_trdy[0]),
    .mmsg_nptrdy_ep    (ep_trdy[1]),
    .tmsg_pcfree_ep    (free_ep[0]),
    .tmsg_npfree_ep    (free_ep[1]),
    .tmsg_pcput_ep     (t_put[0]),
    .tmsg_npput_ep     (t_put[1]),
    .tmsg_pceom_ep     (t_eom[0]),
    .tmsg_npeom_ep     (t_eom[1]),
    .tmsg_pcparity_ep  (t_par[0]),
    .tmsg_npparity_ep  (t_par[1]),
    .tmsg_pcpayload_ep (t_pld[0]),
    .tmsg_nppayload_ep (t_pld[1]),
    .parity_err        (parity_err),
    .fifo_empty        (fifo_empty)
  );

  always #4 agent_clk = ~agent_clk;

  // ----------------------------
  // Helpers
  // ----------------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped on first failure");
  endtask

  task automatic expect_equal(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
      abort_run("Observed value differs from the model");
    end
  endtask

  function automatic logic chance(input int pct);
    return ($unsigned($random(seed)) % 100) < pct;
  endfunction

  // Header flits get a completion opcode about two times in three
  // Data flits now and then carry the same bits in the opcode position
  function automatic logic [`SBREP_PLD_W-1:0] make_payload(input logic hdr);
    sb_flit_u f;
    f.raw = $random(seed);
    if (hdr) begin
      case ($unsigned($random(seed)) % 3)
        0:       f.hdr.opcode = `SBREP_OP_CMPL;
        1:       f.hdr.opcode = `SBREP_OP_CMPLD;
        default: f.hdr.opcode = f.hdr.opcode;
      endcase
    end else if (chance(25)) begin
      f.hdr.opcode = `SBREP_OP_CMPLD;
    end
    return f.raw;
  endfunction

  // Reset values of the control outputs with parity_err from the model
  task automatic check_idle_outputs();
    expect_equal("mmsg_irdy_ep", m_irdy_ep, 2'b00);
    expect_equal("mmsg_sel_ep", sel_ep, 2'b00);
    expect_equal("mmsg_msgip_ip", msgip_ip, 2'b00);
    expect_equal("tmsg_put_ip", t_put_ip, 2'b00);
    expect_equal("tmsg_pccmpl_ip", cmpl, 1'b0);
    expect_equal("mmsg_trdy_ip", trdy_ip, 2'b11);
    expect_equal("tmsg_free_ep", free_ep, 2'b11);
    expect_equal("fifo_empty", fifo_empty, 1'b1);
    expect_equal("parity_err", parity_err, exp_perr);
  endtask

  // ----------------------------
  // Agent and endpoint drivers
  // ----------------------------
  always @(posedge agent_clk) begin : drive_inputs
    logic [`SBREP_PLD_W-1:0] pld;
    logic                    eom;
    for (int c = 0; c < 2; c++) begin
      // Master source holds a flit until trdy takes it
      if (m_acc[c] || !m_irdy[c]) begin
        if (m_left[c] == 0 && gen_en && chance(40)) begin
          m_left[c]  = 1 + ($unsigned($random(seed)) % 4);
          m_first[c] = 1'b1;
        end
        if (m_left[c] != 0 && (m_first[c] || chance(70))) begin
          pld = make_payload(m_first[c]);
          eom = (m_left[c] == 1);
          m_pld[c]  <= pld;
          m_eom[c]  <= eom;
          // Occasional flipped parity bit while injection is on
          m_par[c]  <= ^pld ^ eom ^ (bad_en && chance(10));
          m_irdy[c] <= 1'b1;
          m_left[c]  = m_left[c] - 1;
          m_first[c] = 1'b0;
        end else begin
          m_irdy[c] <= 1'b0;
        end
      end
      ep_trdy[c] <= !hold_sink && chance(60);

      // Target source only puts against predicted free
      if (t_can_put[c] && ((t_left[c] != 0) ? chance(70) : (gen_en && chance(40)))) begin
        if (t_left[c] == 0) begin
          t_left[c]  = 1 + ($unsigned($random(seed)) % 4);
          t_first[c] = 1'b1;
        end
        pld = make_payload(t_first[c]);
        eom = (t_left[c] == 1);
        t_pld[c]  <= pld;
        t_eom[c]  <= eom;
        t_par[c]  <= ^pld ^ eom ^ (bad_en && chance(10));
        t_put[c]  <= 1'b1;
        t_left[c]  = t_left[c] - 1;
        t_first[c] = 1'b0;
      end else begin
        t_put[c] <= 1'b0;
      end
      free_ip[c] <= !hold_sink && chance(60);
    end
  end

  // ----------------------------
  // Monitor and scoreboard
  // ----------------------------
  // Sampled mid-cycle so everything seen here transfers on the next edge
  always @(negedge agent_clk) begin : monitor
    logic [`SBREP_PLD_W:0] head;
    logic                  exp_cmpl;
    sb_flit_u              flit;
    if (rst) begin
      for (int c = 0; c < 2; c++) begin
        mst_q[c].delete();
        tgt_q[c].delete();
      end
      m_acc      = 2'b00;
      t_can_put  = 2'b00;
      exp_msgip  = 2'b00;
      t_open     = 2'b00;
      exp_perr   = 1'b0;
      prev_empty = 1'b1;
      t_hdr      = 1'b1;
      lock_on    = 1'b0;
      lock_ch    = CH_PC;
    end else begin
      // Registered status lags the queues by one edge
      expect_equal("fifo_empty", fifo_empty, prev_empty);
      expect_equal("parity_err", parity_err, exp_perr);
      prev_empty = (mst_q[0].size() == 0) && (mst_q[1].size() == 0) &&
                   (tgt_q[0].size() == 0) && (tgt_q[1].size() == 0);
      expect_equal("mmsg_irdy_ep overlap", m_irdy_ep[0] & m_irdy_ep[1], 1'b0);
      expect_equal("mmsg_sel_ep overlap", sel_ep[0] & sel_ep[1], 1'b0);
      // Mid-message the locked channel keeps the endpoint
      if (lock_on) begin
        expect_equal($sformatf("mmsg_%ssel_ep", chn[lock_ch]), sel_ep[lock_ch], 1'b1);
        expect_equal("mmsg_irdy_ep other channel",
                     (lock_ch == CH_PC) ? m_irdy_ep[1] : m_irdy_ep[0], 1'b0);
      end
      exp_cmpl = 1'b0;

      for (int c = 0; c < 2; c++) begin
        // Master path
        expect_equal($sformatf("mmsg_%strdy_ip", chn[c]), trdy_ip[c],
                     mst_q[c].size() < `SBREP_DEPTH);
        expect_equal($sformatf("mmsg_%smsgip_ip", chn[c]), msgip_ip[c], exp_msgip[c]);
        if (m_irdy_ep[c]) begin
          expect_equal($sformatf("mmsg_%ssel_ep", chn[c]), sel_ep[c], 1'b1);
          if (mst_q[c].size() == 0) begin
            abort_run("Endpoint was offered a master flit that the agent never sent");
          end
          head = mst_q[c][0];
          expect_equal($sformatf("mmsg_%spayload_ep", chn[c]), m_pld_ep[c],
                       head[`SBREP_PLD_W-1:0]);
          expect_equal($sformatf("mmsg_%seom_ep", chn[c]), m_eom_ep[c],
                       head[`SBREP_PLD_W]);
          if (ep_trdy[c]) begin
            void'(mst_q[c].pop_front());
            lock_on = !head[`SBREP_PLD_W];
            lock_ch = sb_chan_e'(c);
          end
        end
        m_acc[c] = m_irdy[c] && trdy_ip[c];
        if (m_acc[c]) begin
          mst_q[c].push_back({m_eom[c], m_pld[c]});
          exp_msgip[c] = !m_eom[c];
          if (m_par[c] != (^m_pld[c] ^ m_eom[c])) begin
            exp_perr = 1'b1;
          end
        end

        // Target path
        expect_equal($sformatf("tmsg_%sfree_ep", chn[c]), free_ep[c],
                     tgt_q[c].size() < `SBREP_DEPTH);
        expect_equal($sformatf("tmsg_%sput_ip", chn[c]), t_put_ip[c],
                     (tgt_q[c].size() != 0) && free_ip[c]);
        if (t_put_ip[c]) begin
          head = tgt_q[c].pop_front();
          expect_equal($sformatf("tmsg_%spayload_ip", chn[c]), t_pld_ip[c],
                       head[`SBREP_PLD_W-1:0]);
          expect_equal($sformatf("tmsg_%seom_ip", chn[c]), t_eom_ip[c],
                       head[`SBREP_PLD_W]);
          // First pc flit after reset or eom is a header
          if (c == 0) begin
            flit.raw = head[`SBREP_PLD_W-1:0];
            exp_cmpl = t_hdr && ((flit.hdr.opcode == `SBREP_OP_CMPL) ||
                                 (flit.hdr.opcode == `SBREP_OP_CMPLD));
            t_hdr    = head[`SBREP_PLD_W];
          end
        end
        if (t_put[c] && free_ep[c]) begin
          tgt_q[c].push_back({t_eom[c], t_pld[c]});
          t_open[c] = !t_eom[c];
          if (t_par[c] != (^t_pld[c] ^ t_eom[c])) begin
            exp_perr = 1'b1;
          end
        end
        t_can_put[c] = tgt_q[c].size() < `SBREP_DEPTH;
      end
      expect_equal("tmsg_pccmpl_ip", cmpl, exp_cmpl);
    end
  end

  // ----------------------------
  // Test sequence
  // ----------------------------
  initial begin
    int  n;
    logic done;
    agent_clk = 1'b0;
    rst       = 1'b1;
    seed      = 32'h1be33fd6;
    chn[0]    = "pc";
    chn[1]    = "np";
    gen_en    = 1'b0;
    hold_sink = 1'b0;
    bad_en    = 1'b0;
    m_irdy    = 2'b00;
    m_eom     = 2'b00;
    m_par     = 2'b00;
    ep_trdy   = 2'b00;
    t_put     = 2'b00;
    t_eom     = 2'b00;
    t_par     = 2'b00;
    free_ip   = 2'b00;
    m_acc     = 2'b00;
    t_can_put = 2'b00;
    for (int c = 0; c < 2; c++) begin
      m_pld[c]   = '0;
      t_pld[c]   = '0;
      m_left[c]  = 0;
      t_left[c]  = 0;
      m_first[c] = 1'b0;
      t_first[c] = 1'b0;
    end

    repeat (10) @(posedge agent_clk);
    rst <= 1'b0;
    @(negedge agent_clk);
    check_idle_outputs();

    // Random traffic with clean parity
    gen_en <= 1'b1;
    repeat (400) @(posedge agent_clk);

    // Stall both sinks until every queue is full
    hold_sink <= 1'b1;
    done = 1'b0;
    for (n = 0; n < 300 && !done; n++) begin
      @(posedge agent_clk);
      done = (mst_q[0].size() == `SBREP_DEPTH) && (mst_q[1].size() == `SBREP_DEPTH) &&
             (tgt_q[0].size() == `SBREP_DEPTH) && (tgt_q[1].size() == `SBREP_DEPTH);
    end
    if (!done) begin
      abort_run("Timeout waiting for all queues to fill under back-pressure");
    end
    @(negedge agent_clk);
    expect_equal("mmsg_trdy_ip when full", trdy_ip, 2'b00);
    expect_equal("tmsg_free_ep when full", free_ep, 2'b00);
    repeat (20) @(posedge agent_clk);
    hold_sink <= 1'b0;

    // Bad parity on some flits and then clean again
    bad_en <= 1'b1;
    repeat (200) @(posedge agent_clk);
    bad_en <= 1'b0;
    repeat (200) @(posedge agent_clk);

    // Drain at message boundaries
    gen_en <= 1'b0;
    done = 1'b0;
    for (n = 0; n < 1000 && !done; n++) begin
      @(posedge agent_clk);
      done = prev_empty && (mst_q[0].size() == 0) && (mst_q[1].size() == 0) &&
             (tgt_q[0].size() == 0) && (tgt_q[1].size() == 0) &&
             (m_irdy == 2'b00) && (t_put == 2'b00) &&
             (exp_msgip == 2'b00) && (t_open == 2'b00);
    end
    if (!done) begin
      abort_run("Timeout waiting for the repeater to drain");
    end
    repeat (2) @(negedge agent_clk);
    check_idle_outputs();
    expect_equal("parity_err after injection", parity_err, 1'b1);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/sberep_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module sberep_ctrl
  import sberep_pkg::*;
(
  input  wire logic       agent_clk,
  input  wire logic       rst,
  // Master egress arbitration
  input  wire logic       pc_avail,
  input  wire logic       np_avail,
  input  wire logic       pc_xfer,
  input  wire logic       np_xfer,
  input  wire logic       xfer_eom,
  output sb_chan_e        grant,
  output logic            grant_valid,
  // Queue status, bits 1:0 master and 3:2 target
  input  wire logic [3:0] par_bad,
  input  wire logic [3:0] q_empty,
  output logic            parity_err,
  output logic            fifo_empty
);

  logic     locked;
  sb_chan_e lock_ch;
  sb_chan_e last_ch;
  sb_chan_e pick;
  logic     xfer;

  assign xfer = pc_xfer | np_xfer;

  // ----------------------------
  // Grant and message lock
  // ----------------------------

  // Round-robin between non-empty queues at a boundary
  always_comb begin
    if (pc_avail && np_avail) begin
      pick = (last_ch == CH_PC) ? CH_NP : CH_PC;
    end else if (np_avail) begin
      pick = CH_NP;
    end else begin
      pick = CH_PC;
    end
  end

  // Lock holds the channel even while its queue runs dry
  assign grant       = locked ? lock_ch : pick;
  assign grant_valid = locked | pc_avail | np_avail;

  always_ff @(posedge agent_clk) begin
    if (rst) begin
      locked  <= 1'b0;
      lock_ch <= CH_PC;
      last_ch <= CH_NP;
    end else if (grant_valid) begin
      if (xfer && xfer_eom) begin
        // Message done, free for the other channel
        locked  <= 1'b0;
        last_ch <= grant;
      end else begin
        locked  <= 1'b1;
        lock_ch <= grant;
      end
    end
  end

  // ----------------------------
  // Status aggregation
  // ----------------------------
  always_ff @(posedge agent_clk) begin
    if (rst) begin
      parity_err <= 1'b0;
      fifo_empty <= 1'b1;
    end else begin
      // Sticky until reset
      if (|par_bad) begin
        parity_err <= 1'b1;
      end
      fifo_empty <= &q_empty;
    end
  end

  // Mid-message the grant is frozen
  a_lock_hold: assert property (@(posedge agent_clk) disable iff (rst)
    (locked && !(xfer && xfer_eom)) |=> (grant == $past(grant)));

  // Datapath only moves flits on the granted channel
  a_xfer_granted: assert property (@(posedge agent_clk) disable iff (rst)
    xfer |-> grant_valid && (pc_xfer ? (grant == CH_PC) : (grant == CH_NP)));

endmodule

`default_nettype wire

//--- verilog/sberep_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "sberep_defines.svh"

module sberep_fifo #(
  parameter int DEPTH = `SBREP_DEPTH
) (
  input  wire logic                    agent_clk,
  input  wire logic                    rst,
  // Write side
  input  wire logic                    wr,
  input  wire logic [`SBREP_PLD_W-1:0] wr_payload,
  input  wire logic                    wr_eom,
  input  wire logic                    wr_parity,
  // Read side, head entry is shown before rd
  input  wire logic                    rd,
  output logic      [`SBREP_PLD_W-1:0] rd_payload,
  output logic                         rd_eom,
  // Status
  output logic                         full,
  output logic                         empty,
  output logic                         parity_bad
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  // Entry storage
  logic [`SBREP_PLD_W-1:0] mem_payload [DEPTH];
  logic                    mem_eom     [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;

  // Pointer step with wrap for any depth
  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
    if (ptr == AW'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // ----------------------------
  // Pointers and occupancy
  // ----------------------------
  always_ff @(posedge agent_clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (rd) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // Read and write together leave count alone
      case ({wr, rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge agent_clk) begin
    if (wr) begin
      mem_payload[wr_ptr] <= wr_payload;
      mem_eom[wr_ptr]     <= wr_eom;
    end
  end

  assign rd_payload = mem_payload[rd_ptr];
  assign rd_eom     = mem_eom[rd_ptr];

  // Full drops ready on the same edge as the filling write
  assign full  = (count == CW'(DEPTH));
  assign empty = (count == '0);

  // Parity covers payload bits and eom
  assign parity_bad = wr && ((^wr_payload ^ wr_eom) != wr_parity);

  // Ready/free gating in the parent must keep these off
  a_no_wr_full: assert property (@(posedge agent_clk) disable iff (rst) wr |-> !full);
  a_no_rd_empty: assert property (@(posedge agent_clk) disable iff (rst) rd |-> !empty);

endmodule

`default_nettype wire

//--- verilog/sberep_mst.sv
`timescale 1ns/100ps
`default_nettype none

`include "sberep_defines.svh"

module sberep_mst
  import sberep_pkg::*;
(
  input  wire logic                    agent_clk,
  input  wire logic                    rst,
  // Agent side
  input  wire logic                    mmsg_pcirdy_ip,
  input  wire logic                    mmsg_npirdy_ip,
  input  wire logic                    mmsg_pceom_ip,
  input  wire logic                    mmsg_npeom_ip,
  input  wire logic                    mmsg_pcparity_ip,
  input  wire logic                    mmsg_npparity_ip,
  input  wire logic [`SBREP_PLD_W-1:0] mmsg_pcpayload_ip,
  input  wire logic [`SBREP_PLD_W-1:0] mmsg_nppayload_ip,
  output logic                         mmsg_pctrdy_ip,
  output logic                         mmsg_nptrdy_ip,
  output logic                         mmsg_pcmsgip_ip,
  output logic                         mmsg_npmsgip_ip,
  // Endpoint side
  output logic                         mmsg_pcirdy_ep,
  output logic                         mmsg_npirdy_ep,
  output logic                         mmsg_pceom_ep,
  output logic                         mmsg_npeom_ep,
  output logic      [`SBREP_PLD_W-1:0] mmsg_pcpayload_ep,
  output logic      [`SBREP_PLD_W-1:0] mmsg_nppayload_ep,
  output logic                         mmsg_pcsel_ep,
  output logic                         mmsg_npsel_ep,
  input  wire logic                    mmsg_pctrdy_ep,
  input  wire logic                    mmsg_nptrdy_ep,
  // Arbiter handshake
  input  wire sb_chan_e                grant,
  input  wire logic                    grant_valid,
  output logic                         pc_avail,
  output logic                         np_avail,
  output logic                         pc_xfer,
  output logic                         np_xfer,
  output logic                         xfer_eom,
  output logic      [1:0]              q_empty,
  output logic      [1:0]              par_bad
);

  logic pc_wr;
  logic np_wr;
  logic pc_full;
  logic np_full;

  // ----------------------------
  // Ingress from the agent
  // ----------------------------
  assign mmsg_pctrdy_ip = !pc_full;
  assign mmsg_nptrdy_ip = !np_full;
  assign pc_wr = mmsg_pcirdy_ip && mmsg_pctrdy_ip;
  assign np_wr = mmsg_npirdy_ip && mmsg_nptrdy_ip;

  // Message in progress, set mid-message and cleared by eom
  always_ff @(posedge agent_clk) begin
    if (rst) begin
      mmsg_pcmsgip_ip <= 1'b0;
      mmsg_npmsgip_ip <= 1'b0;
    end else begin
      if (pc_wr) begin
        mmsg_pcmsgip_ip <= !mmsg_pceom_ip;
      end
      if (np_wr) begin
        mmsg_npmsgip_ip <= !mmsg_npeom_ip;
      end
    end
  end

  sberep_fifo #(.DEPTH(`SBREP_DEPTH)) i_pc_fifo (
    .agent_clk  (agent_clk),
    .rst        (rst),
    .wr         (pc_wr),
    .wr_payload (mmsg_pcpayload_ip),
    .wr_eom     (mmsg_pceom_ip),
    .wr_parity  (mmsg_pcparity_ip),
    .rd         (pc_xfer),
    .rd_payload (mmsg_pcpayload_ep),
    .rd_eom     (mmsg_pceom_ep),
    .full       (pc_full),
    .empty      (q_empty[0]),
    .parity_bad (par_bad[0])
  );

  sberep_fifo #(.DEPTH(`SBREP_DEPTH)) i_np_fifo (
    .agent_clk  (agent_clk),
    .rst        (rst),
    .wr         (np_wr),
    .wr_payload (mmsg_nppayload_ip),
    .wr_eom     (mmsg_npeom_ip),
    .wr_parity  (mmsg_npparity_ip),
    .rd         (np_xfer),
    .rd_payload (mmsg_nppayload_ep),
    .rd_eom     (mmsg_npeom_ep),
    .full       (np_full),
    .empty      (q_empty[1]),
    .parity_bad (par_bad[1])
  );

  // ----------------------------
  // Egress to the endpoint
  // ----------------------------
  assign pc_avail = !q_empty[0];
  assign np_avail = !q_empty[1];

  // One-hot select straight from the grant
  assign mmsg_pcsel_ep = grant_valid && (grant == CH_PC);
  assign mmsg_npsel_ep = grant_valid && (grant == CH_NP);

  // irdy only on the selected channel with data waiting
  assign mmsg_pcirdy_ep = mmsg_pcsel_ep && pc_avail;
  assign mmsg_npirdy_ep = mmsg_npsel_ep && np_avail;

  assign pc_xfer  = mmsg_pcirdy_ep && mmsg_pctrdy_ep;
  assign np_xfer  = mmsg_npirdy_ep && mmsg_nptrdy_ep;
  assign xfer_eom = (pc_xfer && mmsg_pceom_ep) || (np_xfer && mmsg_npeom_ep);

endmodule

`default_nettype wire

//--- verilog/sberep_pkg.sv
`default_nettype none

`include "sberep_defines.svh"

package sberep_pkg;

  // One payload word, read raw on data flits
  // and as a header on the first flit of a message
  typedef union packed {
    logic [`SBREP_PLD_W-1:0] raw;
    struct packed {
      logic [4:0] misc;
      logic [2:0] tag;
      logic [7:0] opcode;
      logic [7:0] src;
      // Destination port id sits in the low byte
      logic [7:0] dest;
    } hdr;
  } sb_flit_u;

  // Posted and non-posted channel index
  typedef enum logic {
    CH_PC = 1'b0,
    CH_NP = 1'b1
  } sb_chan_e;

endpackage

`default_nettype wire

//--- verilog/sberep_tgt.sv
`timescale 1ns/100ps
`default_nettype none

`include "sberep_defines.svh"

module sberep_tgt
  import sberep_pkg::*;
(
  input  wire logic                    agent_clk,
  input  wire logic                    rst,
  // Agent side
  input  wire logic                    tmsg_pcfree_ip,
  input  wire logic                    tmsg_npfree_ip,
  output logic                         tmsg_pcput_ip,
  output logic                         tmsg_npput_ip,
  output logic                         tmsg_pceom_ip,
  output logic                         tmsg_npeom_ip,
  output logic      [`SBREP_PLD_W-1:0] tmsg_pcpayload_ip,
  output logic      [`SBREP_PLD_W-1:0] tmsg_nppayload_ip,
  output logic                         tmsg_pccmpl_ip,
  // Endpoint side
  output logic                         tmsg_pcfree_ep,
  output logic                         tmsg_npfree_ep,
  input  wire logic                    tmsg_pcput_ep,
  input  wire logic                    tmsg_npput_ep,
  input  wire logic                    tmsg_pceom_ep,
  input  wire logic                    tmsg_npeom_ep,
  input  wire logic                    tmsg_pcparity_ep,
  input  wire logic                    tmsg_npparity_ep,
  input  wire logic [`SBREP_PLD_W-1:0] tmsg_pcpayload_ep,
  input  wire logic [`SBREP_PLD_W-1:0] tmsg_nppayload_ep,
  // Status to control
  output logic      [1:0]              q_empty,
  output logic      [1:0]              par_bad
);

  logic     pc_wr;
  logic     np_wr;
  logic     pc_full;
  logic     np_full;
  logic     pc_hdr;
  sb_flit_u pc_head;

  // ----------------------------
  // Ingress from the endpoint
  // ----------------------------
  assign tmsg_pcfree_ep = !pc_full;
  assign tmsg_npfree_ep = !np_full;
  assign pc_wr = tmsg_pcput_ep && tmsg_pcfree_ep;
  assign np_wr = tmsg_npput_ep && tmsg_npfree_ep;

  sberep_fifo #(.DEPTH(`SBREP_DEPTH)) i_pc_fifo (
    .agent_clk  (agent_clk),
    .rst        (rst),
    .wr         (pc_wr),
    .wr_payload (tmsg_pcpayload_ep),
    .wr_eom     (tmsg_pceom_ep),
    .wr_parity  (tmsg_pcparity_ep),
    .rd         (tmsg_pcput_ip),
    .rd_payload (pc_head),
    .rd_eom     (tmsg_pceom_ip),
    .full       (pc_full),
    .empty      (q_empty[0]),
    .parity_bad (par_bad[0])
  );

  sberep_fifo #(.DEPTH(`SBREP_DEPTH)) i_np_fifo (
    .agent_clk  (agent_clk),
    .rst        (rst),
    .wr         (np_wr),
    .wr_payload (tmsg_nppayload_ep),
    .wr_eom     (tmsg_npeom_ep),
    .wr_parity  (tmsg_npparity_ep),
    .rd         (tmsg_npput_ip),
    .rd_payload (tmsg_nppayload_ip),
    .rd_eom     (tmsg_npeom_ip),
    .full       (np_full),
    .empty      (q_empty[1]),
    .parity_bad (par_bad[1])
  );

  // ----------------------------
  // Egress to the agent
  // ----------------------------

  // Each put moves one flit, only against agent free
  assign tmsg_pcput_ip = !q_empty[0] && tmsg_pcfree_ip;
  assign tmsg_npput_ip = !q_empty[1] && tmsg_npfree_ip;
  assign tmsg_pcpayload_ip = pc_head.raw;

  // Next pc flit out is a header after reset or after eom
  always_ff @(posedge agent_clk) begin
    if (rst) begin
      pc_hdr <= 1'b1;
    end else if (tmsg_pcput_ip) begin
      pc_hdr <= tmsg_pceom_ip;
    end
  end

  // Completion flag rides with the header put
  assign tmsg_pccmpl_ip = tmsg_pcput_ip && pc_hdr &&
                          ((pc_head.hdr.opcode == `SBREP_OP_CMPL) ||
                           (pc_head.hdr.opcode == `SBREP_OP_CMPLD));

  // Endpoint only puts against free
  a_pc_put_free: assert property (@(posedge agent_clk) disable iff (rst)
    tmsg_pcput_ep |-> tmsg_pcfree_ep);
  a_np_put_free: assert property (@(posedge agent_clk) disable iff (rst)
    tmsg_npput_ep |-> tmsg_npfree_ep);

endmodule

`default_nettype wire

//--- verilog/sberepeater.sv
`timescale 1ns/100ps
`default_nettype none

`include "sberep_defines.svh"

module sberepeater
  import sberep_pkg::*;
(
  input  wire logic                    agent_clk,
  input  wire logic                    rst,
  // ----------------------------
  // Agent interface
  // ----------------------------
  input  wire logic                    mmsg_pcirdy_ip,
  input  wire logic                    mmsg_npirdy_ip,
  input  wire logic                    mmsg_pceom_ip,
  input  wire logic                    mmsg_npeom_ip,
  input  wire logic                    mmsg_pcparity_ip,
  input  wire logic                    mmsg_npparity_ip,
  input  wire logic [`SBREP_PLD_W-1:0] mmsg_pcpayload_ip,
  input  wire logic [`SBREP_PLD_W-1:0] mmsg_nppayload_ip,
  output logic                         mmsg_pctrdy_ip,
  output logic                         mmsg_nptrdy_ip,
  output logic                         mmsg_pcmsgip_ip,
  output logic                         mmsg_npmsgip_ip,
  input  wire logic                    tmsg_pcfree_ip,
  input  wire logic                    tmsg_npfree_ip,
  output logic                         tmsg_pcput_ip,
  output logic                         tmsg_npput_ip,
  output logic                         tmsg_pceom_ip,
  output logic                         tmsg_npeom_ip,
  output logic      [`SBREP_PLD_W-1:0] tmsg_pcpayload_ip,
  output logic      [`SBREP_PLD_W-1:0] tmsg_nppayload_ip,
  output logic                         tmsg_pccmpl_ip,
  // ----------------------------
  // Endpoint interface
  // ----------------------------
  output logic                         mmsg_pcirdy_ep,
  output logic                         mmsg_npirdy_ep,
  output logic                         mmsg_pceom_ep,
  output logic                         mmsg_npeom_ep,
  output logic      [`SBREP_PLD_W-1:0] mmsg_pcpayload_ep,
  output logic      [`SBREP_PLD_W-1:0] mmsg_nppayload_ep,
  output logic                         mmsg_pcsel_ep,
  output logic                         mmsg_npsel_ep,
  input  wire logic                    mmsg_pctrdy_ep,
  input  wire logic                    mmsg_nptrdy_ep,
  output logic                         tmsg_pcfree_ep,
  output logic                         tmsg_npfree_ep,
  input  wire logic                    tmsg_pcput_ep,
  input  wire logic                    tmsg_npput_ep,
  input  wire logic                    tmsg_pceom_ep,
  input  wire logic                    tmsg_npeom_ep,
  input  wire logic                    tmsg_pcparity_ep,
  input  wire logic                    tmsg_npparity_ep,
  input  wire logic [`SBREP_PLD_W-1:0] tmsg_pcpayload_ep,
  input  wire logic [`SBREP_PLD_W-1:0] tmsg_nppayload_ep,
  // Status
  output logic                         parity_err,
  output logic                         fifo_empty
);

  // Master egress arbitration
  sb_chan_e   grant;
  logic       grant_valid;
  logic       pc_avail;
  logic       np_avail;
  logic       pc_xfer;
  logic       np_xfer;
  logic       xfer_eom;

  // Per-path queue status, pc in bit 0
  logic [1:0] mst_empty;
  logic [1:0] tgt_empty;
  logic [1:0] mst_par_bad;
  logic [1:0] tgt_par_bad;

  sberep_ctrl i_sberep_ctrl (
    .*,
    .par_bad (({tgt_par_bad, mst_par_bad})),
    .q_empty (({tgt_empty, mst_empty}))
  );

  sberep_mst i_sberep_mst (
    .*,
    .q_empty (mst_empty),
    .par_bad (mst_par_bad)
  );

  sberep_tgt i_sberep_tgt (
    .*,
    .q_empty (tgt_empty),
    .par_bad (tgt_par_bad)
  );

endmodule

`default_nettype wire
